// ==== sim.f ====
+incdir+src
src/fabric_pkg.sv
src/bus_decoder.sv
src/mem_arbiter.sv
src/shared_mem.sv
src/video_fetch.sv
src/irq_encoder.sv
src/fabric_top.sv
verif/fabric_properties.sv
verif/fabric_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fabric testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module fabric_tb -f sim.f -o fabric_sim

# the log decides pass or fail, so a stopped run is still judged
./obj_dir/fabric_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// ==== verif/fabric_tb.sv ====
`include "fabric_params.svh"

module fabric_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fabric_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_FILL = `FAB_MEM_WORDS;
  localparam int N_RAND = 64;
  localparam int N_CTRL = 8;
  localparam int N_IRQ = 16;
  localparam int N_BG = 40;
  localparam int FRAMES = 3;
  localparam int FRAME_WORDS = 12;
  localparam int N_OPS = N_FILL + 2 * N_RAND + 8 * N_CTRL + 2 * N_IRQ + 2 * N_BG + 16;
  localparam int WATCH_CYCLES = N_OPS * 20 + FRAMES * FRAME_WORDS * 20 + 8;
  localparam logic [7:0] VBASE = 8'd16;
  localparam logic [7:0] VLEN = 8'(FRAME_WORDS);

  logic        sysclock = 1'b0;
  logic        rst_i;
  bus_req_t    cpu_req;
  bus_rsp_t    cpu_rsp;
  logic [5:0]  irq_lines;
  logic        pix_ready = 1'b0;
  pix_t        pix;
  logic        pix_valid;
  irq_lvl_t    irq;

  integer      seed = 32'he3b8;
  int          errors = 0;
  int          pix_errors = 0;
  logic [31:0] shadow [`FAB_MEM_WORDS];
  logic [31:0] ctrl_shadow [4];
  logic [7:0]  written [$];  // words touched by partial writes
  logic [31:0] tmp;
  bus_rsp_t    rsp;
  logic        stream_on = 1'b0;
  logic        ready_pat [64];
  logic [5:0]  ready_idx = 6'd0;
  logic [7:0]  pix_pos = 8'd0;
  int          pix_count = 0;
  pix_t        exp_pix;

  fabric_top dut0 (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .cpu_req_i   (cpu_req),
    .irq_lines_i (irq_lines),
    .pix_ready_i (pix_ready),
    .cpu_rsp_o   (cpu_rsp),
    .pix_o       (pix),
    .pix_valid_o (pix_valid),
    .irq_o       (irq)
  );

  always #(CLK_PERIOD / 2) sysclock = ~sysclock;

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // fault first, then lines 5..2, then 1 and 0 at the top levels
  function automatic irq_lvl_t ref_irq(input logic fault, input logic [5:0] lines,
                                       input logic en);
    irq_lvl_t lvl;
    if (!en) lvl = 3'd0;
    else if (fault) lvl = 3'd1;
    else if (lines[5]) lvl = 3'd5;
    else if (lines[4]) lvl = 3'd4;
    else if (lines[3]) lvl = 3'd3;
    else if (lines[2]) lvl = 3'd2;
    else if (lines[1]) lvl = 3'd6;
    else if (lines[0]) lvl = 3'd7;
    else lvl = 3'd0;
    return lvl;
  endfunction

  task automatic check_rsp(input bus_rsp_t got, input logic [31:0] exp_dat,
                           input logic exp_err, input logic use_dat, input string what);
    if (got.err !== exp_err || (use_dat && got.dat !== exp_dat)) begin
      $display("error %0t: %s got dat %h err %b, expected dat %h err %b",
               $time, what, got.dat, got.err, exp_dat, exp_err);
      errors++;
    end
  endtask

  task automatic check_pix(input pix_t got, input pix_t exp);
    if (got !== exp) begin
      $display("error %0t: pixel got %h last %b, expected %h last %b",
               $time, got.dat, got.last, exp.dat, exp.last);
      pix_errors++;
    end
  endtask

  task automatic check_irq(input irq_lvl_t got, input irq_lvl_t exp);
    if (got !== exp) begin
      $display("error %0t: irq level got %0d, expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  // one cpu transaction, held until ack
  task automatic bus_xfer(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                          input logic [31:0] dat, output bus_rsp_t got);
    bus_req_t req;
    req = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = we;
    req.sel = sel;
    req.adr = adr;
    req.dat = dat;
    @(posedge sysclock);
    cpu_req <= req;
    do begin
      @(negedge sysclock);
    end while (!cpu_rsp.ack);
    got = cpu_rsp;
    @(posedge sysclock);
    cpu_req <= '0;
  endtask

  task automatic mem_write(input logic [7:0] w, input logic [3:0] sel, input logic [31:0] dat);
    bus_rsp_t got;
    bus_xfer(1'b1, sel, {22'd0, w, 2'b00}, dat, got);
    check_rsp(got, 32'd0, 1'b0, 1'b0, $sformatf("memory write word %0d", w));
    shadow[w] = merge_lanes(shadow[w], dat, sel);
  endtask

  task automatic mem_read_check(input logic [7:0] w);
    bus_rsp_t got;
    bus_xfer(1'b0, 4'hf, {22'd0, w, 2'b00}, 32'd0, got);
    check_rsp(got, shadow[w], 1'b0, 1'b1, $sformatf("memory read word %0d", w));
  endtask

  task automatic ctrl_write(input logic [1:0] idx, input logic [3:0] sel, input logic [31:0] dat);
    bus_rsp_t got;
    bus_xfer(1'b1, sel, {4'h1, 24'd0, idx, 2'b00}, dat, got);
    check_rsp(got, 32'd0, 1'b0, 1'b0, $sformatf("ctrl write reg %0d", idx));
    if (idx == 2'd2) begin
      if (sel[0]) ctrl_shadow[2] = {30'd0, dat[1:0]};  // only enable bits exist
    end else if (idx != 2'd3) begin
      ctrl_shadow[idx] = merge_lanes(ctrl_shadow[idx], dat, sel);
    end
  endtask

  task automatic ctrl_read_check(input logic [1:0] idx);
    bus_rsp_t got;
    bus_xfer(1'b0, 4'hf, {4'h1, 24'd0, idx, 2'b00}, 32'd0, got);
    check_rsp(got, ctrl_shadow[idx], 1'b0, 1'b1, $sformatf("ctrl read reg %0d", idx));
  endtask

  task automatic wait_irq(input irq_lvl_t want);
    int n;
    n = 0;
    do begin
      @(negedge sysclock);
      n++;
    end while (irq !== want && n < 6);
    check_irq(irq, want);
  endtask

  // downstream sink with back-pressure
  always @(posedge sysclock) begin
    pix_ready <= stream_on & ready_pat[ready_idx];
    ready_idx <= ready_idx + 6'd1;
  end

  // compare every accepted pixel against the shadow frame
  always @(negedge sysclock) begin
    if (stream_on && pix_valid && pix_ready) begin
      exp_pix.dat = shadow[VBASE + pix_pos];
      exp_pix.last = (pix_pos == VLEN - 8'd1);
      check_pix(pix, exp_pix);
      pix_pos = (pix_pos == VLEN - 8'd1) ? 8'd0 : pix_pos + 8'd1;
      pix_count = pix_count + 1;
    end
  end

  initial begin
    cpu_req = '0;
    irq_lines = 6'd0;
    rst_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      ctrl_shadow[i] = 32'd0;
    end
    repeat (8) @(posedge sysclock);
    rst_i <= 1'b0;
    @(negedge sysclock);
    if (cpu_rsp.ack !== 1'b0 || pix_valid !== 1'b0) begin
      $display("error %0t: ack or pixel valid not low after reset", $time);
      errors++;
    end
    check_irq(irq, 3'd0);

    // full fill, partial writes, readback of touched words
    for (int i = 0; i < N_FILL; i++) begin
      mem_write(i[7:0], 4'hf, next_rand());
    end
    for (int i = 0; i < N_RAND; i++) begin
      tmp = next_rand();
      mem_write(tmp[7:0], tmp[11:8], next_rand());
      written.push_back(tmp[7:0]);
    end
    foreach (written[j]) begin
      mem_read_check(written[j]);
    end

    for (int i = 0; i < N_CTRL; i++) begin
      tmp = next_rand();
      ctrl_write(2'd0, tmp[3:0], next_rand());
      tmp = next_rand();
      ctrl_write(2'd1, tmp[3:0], next_rand());
      tmp = next_rand();
      ctrl_write(2'd2, tmp[3:0], {tmp[31:1], 1'b0});  // video stays off
      for (int k = 0; k < 4; k++) begin
        ctrl_read_check(k[1:0]);
      end
    end

    // unmapped access, fault outranks the device lines
    ctrl_write(2'd2, 4'h1, 32'h2);
    bus_xfer(1'b0, 4'hf, 32'h3000_0010, 32'd0, rsp);
    check_rsp(rsp, 32'd0, 1'b1, 1'b0, "unmapped access");
    wait_irq(3'd1);
    @(posedge sysclock);
    irq_lines <= 6'b001010;
    repeat (2) @(negedge sysclock);
    check_irq(irq, ref_irq(1'b1, irq_lines, 1'b1));
    ctrl_read_check(2'd0);  // mapped access clears fault
    wait_irq(ref_irq(1'b0, irq_lines, 1'b1));

    for (int i = 0; i < 2 * N_IRQ; i++) begin
      if (i == N_IRQ) begin
        ctrl_write(2'd2, 4'h1, 32'h0);
      end
      tmp = next_rand();
      @(posedge sysclock);
      irq_lines <= tmp[5:0];
      @(posedge sysclock);
      @(negedge sysclock);
      check_irq(irq, ref_irq(1'b0, irq_lines, ctrl_shadow[2][1]));
    end

    // video stream with cpu traffic kept clear of the frame
    for (int i = 0; i < 64; i++) begin
      tmp = next_rand();
      ready_pat[i] = tmp[0] | tmp[1];
    end
    ctrl_write(2'd0, 4'hf, {24'd0, VBASE});
    ctrl_write(2'd1, 4'hf, {24'd0, VLEN});
    stream_on <= 1'b1;
    ctrl_write(2'd2, 4'h1, 32'h1);
    for (int i = 0; i < N_BG; i++) begin
      tmp = next_rand();
      mem_write({1'b1, tmp[6:0]}, tmp[11:8], next_rand());
      tmp = next_rand();
      mem_read_check({1'b1, tmp[6:0]});
    end
    wait (pix_count >= FRAMES * FRAME_WORDS);

    $display("errors: bus and irq %0d, pixel stream %0d", errors, pix_errors);
    if (errors == 0 && pix_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
    $display("errors: bus and irq %0d, pixel stream %0d", errors, pix_errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== verif/fabric_properties.sv ====
module fabric_properties (
  input logic                 sysclock,
  input logic                 rst_i,
  input logic                 gnt_cpu_i,
  input logic                 gnt_vid_i,
  input logic                 busy_i,
  input logic                 owner_i,
  input fabric_pkg::bus_rsp_t mem_rsp_i,
  input fabric_pkg::bus_rsp_t cpu_rsp_i,
  input fabric_pkg::bus_rsp_t vid_rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // each memory ack belongs to exactly one owner
  one_owner: assert property (@(posedge sysclock) disable iff (rst_i)
    mem_rsp_i.ack |-> (cpu_rsp_i.ack != vid_rsp_i.ack))
    else $error("memory ack reached no owner or both masters");

  // grant may only move after the memory ack
  cpu_gnt_held: assert property (@(posedge sysclock) disable iff (rst_i)
    gnt_cpu_i && !mem_rsp_i.ack |=> gnt_cpu_i)
    else $error("cpu grant dropped before ack");

  vid_gnt_held: assert property (@(posedge sysclock) disable iff (rst_i)
    gnt_vid_i && !mem_rsp_i.ack |=> gnt_vid_i)
    else $error("video grant dropped before ack");

  cpu_ack_owner: assert property (@(posedge sysclock) disable iff (rst_i)
    cpu_rsp_i.ack |-> busy_i && !owner_i)
    else $error("cpu saw ack without owning the memory");

  vid_ack_owner: assert property (@(posedge sysclock) disable iff (rst_i)
    vid_rsp_i.ack |-> busy_i && owner_i)
    else $error("video master saw ack without owning the memory");

endmodule

bind mem_arbiter fabric_properties props0 (
  .sysclock  (sysclock),
  .rst_i     (rst_i),
  .gnt_cpu_i (gnt_cpu),
  .gnt_vid_i (gnt_vid),
  .busy_i    (busy_q),
  .owner_i   (owner_q),
  .mem_rsp_i (mem_rsp_i),
  .cpu_rsp_i (cpu_rsp_o),
  .vid_rsp_i (vid_rsp_o)
);

// ==== src/fabric_top.sv ====
module fabric_top (
  input  logic                 sysclock,
  input  logic                 rst_i,
  input  fabric_pkg::bus_req_t cpu_req_i,
  input  logic [5:0]           irq_lines_i,
  input  logic                 pix_ready_i,
  output fabric_pkg::bus_rsp_t cpu_rsp_o,
  output fabric_pkg::pix_t     pix_o,
  output logic                 pix_valid_o,
  output fabric_pkg::irq_lvl_t irq_o
);
  import fabric_pkg::*;

  bus_req_t    cpu_mem_req;
  bus_rsp_t    cpu_mem_rsp;
  bus_req_t    vid_req;
  bus_rsp_t    vid_rsp;
  bus_req_t    mem_req;
  bus_rsp_t    mem_rsp;
  logic [31:0] vid_base;
  logic [31:0] vid_len;
  logic        vid_en;
  logic        int_en;
  logic        fault;

  bus_decoder dec0 (
    .sysclock   (sysclock),
    .rst_i      (rst_i),
    .cpu_req_i  (cpu_req_i),
    .mem_rsp_i  (cpu_mem_rsp),
    .cpu_rsp_o  (cpu_rsp_o),
    .mem_req_o  (cpu_mem_req),
    .vid_base_o (vid_base),
    .vid_len_o  (vid_len),
    .vid_en_o   (vid_en),
    .int_en_o   (int_en),
    .fault_o    (fault)
  );

  mem_arbiter arb0 (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .cpu_req_i (cpu_mem_req),
    .vid_req_i (vid_req),
    .mem_rsp_i (mem_rsp),
    .cpu_rsp_o (cpu_mem_rsp),
    .vid_rsp_o (vid_rsp),
    .mem_req_o (mem_req)
  );

  shared_mem mem0 (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .req_i    (mem_req),
    .rsp_o    (mem_rsp)
  );

  video_fetch vid0 (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .base_i      (vid_base),
    .len_i       (vid_len),
    .en_i        (vid_en),
    .rsp_i       (vid_rsp),
    .pix_ready_i (pix_ready_i),
    .req_o       (vid_req),
    .pix_o       (pix_o),
    .pix_valid_o (pix_valid_o)
  );

  irq_encoder irq0 (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .int_en_i    (int_en),
    .fault_i     (fault),
    .irq_lines_i (irq_lines_i),
    .irq_o       (irq_o)
  );

endmodule

// ==== src/irq_encoder.sv ====
module irq_encoder (
  input  logic                 sysclock,
  input  logic                 rst_i,
  input  logic                 int_en_i,
  input  logic                 fault_i,
  input  logic [5:0]           irq_lines_i,
  output fabric_pkg::irq_lvl_t irq_o
);
  import fabric_pkg::*;

  irq_lvl_t lvl;

  // fixed priority, fault first
  always_comb begin
    casez ({fault_i, irq_lines_i})
      7'b1??????: lvl = 3'd1;
      7'b01?????: lvl = 3'd5;
      7'b001????: lvl = 3'd4;
      7'b0001???: lvl = 3'd3;
      7'b00001??: lvl = 3'd2;
      7'b000001?: lvl = 3'd6;
      7'b0000001: lvl = 3'd7;
      default:    lvl = 3'd0;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      irq_o <= 3'd0;
    end else begin
      irq_o <= int_en_i ? lvl : 3'd0;
    end
  end

endmodule

// ==== src/video_fetch.sv ====
`include "fabric_params.svh"

module video_fetch (
  input  logic                 sysclock,
  input  logic                 rst_i,
  input  logic [31:0]          base_i,
  input  logic [31:0]          len_i,
  input  logic                 en_i,
  input  fabric_pkg::bus_rsp_t rsp_i,
  input  logic                 pix_ready_i,
  output fabric_pkg::bus_req_t req_o,
  output fabric_pkg::pix_t     pix_o,
  output logic                 pix_valid_o
);
  import fabric_pkg::*;

  logic [31:0] addr_q;  // word index of next read
  logic [31:0] cnt_q;   // position within frame
  logic        pend_q;
  logic        valid_q;
  pix_t        pix_q;
  logic        pop;
  logic        is_last;
  logic        issue;
  logic        done;

  assign pop = valid_q & pix_ready_i;
  assign is_last = (cnt_q + 32'd1) >= len_i;
  assign done = pend_q & rsp_i.ack;
  // one read in flight, only when the output word has room
  assign issue = en_i & ~pend_q & (~valid_q | pop);

  always_comb begin
    req_o = '0;
    req_o.cyc = pend_q;
    req_o.stb = pend_q;
    req_o.sel = 4'hf;
    req_o.adr = {addr_q[`FAB_ADDR_W-3:0], 2'b00};
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= 32'd0;
      cnt_q <= 32'd0;
      pend_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (issue) begin
        pend_q <= 1'b1;
      end else if (done) begin
        pend_q <= 1'b0;
      end

      if (done) begin
        valid_q <= 1'b1;
      end else if (pop) begin
        valid_q <= 1'b0;
      end

      if (done) begin
        if (is_last) begin  // wrap to start of frame
          addr_q <= base_i;
          cnt_q <= 32'd0;
        end else begin
          addr_q <= addr_q + 32'd1;
          cnt_q <= cnt_q + 32'd1;
        end
      end else if (!en_i && !pend_q) begin
        addr_q <= base_i;  // restart from base on next enable
        cnt_q <= 32'd0;
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (done) begin
      pix_q.last <= is_last;
      pix_q.dat <= rsp_i.dat;
    end
  end

  assign pix_o = pix_q;
  assign pix_valid_o = valid_q;

endmodule

// ==== src/shared_mem.sv ====
`include "fabric_params.svh"

module shared_mem (
  input  logic                 sysclock,
  input  logic                 rst_i,
  input  fabric_pkg::bus_req_t req_i,
  output fabric_pkg::bus_rsp_t rsp_o
);
  import fabric_pkg::*;

  localparam int AW = $clog2(`FAB_MEM_WORDS);

  logic [31:0]   mem [`FAB_MEM_WORDS];
  logic [AW-1:0] idx;
  logic          start;
  logic          stg0_q;
  logic          stg1_q;
  logic [31:0]   rdat_q;

  assign idx = req_i.adr[AW+1:2];

  // held request must not restart until its ack is out
  assign start = req_i.cyc & req_i.stb & ~stg0_q & ~stg1_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      stg0_q <= 1'b0;
      stg1_q <= 1'b0;
    end else begin
      stg0_q <= start;
      stg1_q <= stg0_q;
    end
  end

  always_ff @(posedge sysclock) begin
    if (start && req_i.we) begin
      mem[idx] <= merge_bytes(mem[idx], req_i.dat, req_i.sel);
    end
    // address still held in the second cycle
    if (stg0_q) begin
      rdat_q <= mem[idx];
    end
  end

  assign rsp_o.ack = stg1_q;
  assign rsp_o.err = 1'b0;  // every word is mapped
  assign rsp_o.dat = rdat_q;

endmodule

// ==== src/mem_arbiter.sv ====
module mem_arbiter (
  input  logic                 sysclock,
  input  logic                 rst_i,
  input  fabric_pkg::bus_req_t cpu_req_i,
  input  fabric_pkg::bus_req_t vid_req_i,
  input  fabric_pkg::bus_rsp_t mem_rsp_i,
  output fabric_pkg::bus_rsp_t cpu_rsp_o,
  output fabric_pkg::bus_rsp_t vid_rsp_o,
  output fabric_pkg::bus_req_t mem_req_o
);

  logic cpu_want;
  logic vid_want;
  logic pick_vid;
  logic gnt_cpu;
  logic gnt_vid;
  logic busy_q;
  logic owner_q;  // 1 = video
  logic last_q;   // owner of previous transfer, 1 = video

  assign cpu_want = cpu_req_i.cyc & cpu_req_i.stb;
  assign vid_want = vid_req_i.cyc & vid_req_i.stb;

  // on contention whoever did not go last wins
  assign pick_vid = vid_want & (~cpu_want | ~last_q);

  assign gnt_vid = busy_q ? owner_q : pick_vid;
  assign gnt_cpu = busy_q ? ~owner_q : (cpu_want & ~pick_vid);

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      owner_q <= 1'b0;
      last_q <= 1'b0;
    end else if (mem_rsp_i.ack) begin
      busy_q <= 1'b0;
      last_q <= owner_q;
    end else if (!busy_q && (gnt_cpu || gnt_vid)) begin
      busy_q <= 1'b1;
      owner_q <= gnt_vid;
    end
  end

  always_comb begin
    mem_req_o = gnt_vid ? vid_req_i : cpu_req_i;
    mem_req_o.cyc = mem_req_o.cyc & (gnt_cpu | gnt_vid);
    mem_req_o.stb = mem_req_o.stb & (gnt_cpu | gnt_vid);
  end

  always_comb begin
    cpu_rsp_o = mem_rsp_i;
    cpu_rsp_o.ack = mem_rsp_i.ack & gnt_cpu;
    cpu_rsp_o.err = mem_rsp_i.err & gnt_cpu;
    vid_rsp_o = mem_rsp_i;
    vid_rsp_o.ack = mem_rsp_i.ack & gnt_vid;
    vid_rsp_o.err = mem_rsp_i.err & gnt_vid;
  end

endmodule

// ==== src/bus_decoder.sv ====
`include "fabric_params.svh"

module bus_decoder (
  input  logic                 sysclock,
  input  logic                 rst_i,
  input  fabric_pkg::bus_req_t cpu_req_i,
  input  fabric_pkg::bus_rsp_t mem_rsp_i,
  output fabric_pkg::bus_rsp_t cpu_rsp_o,
  output fabric_pkg::bus_req_t mem_req_o,
  output logic [31:0]          vid_base_o,
  output logic [31:0]          vid_len_o,
  output logic                 vid_en_o,
  output logic                 int_en_o,
  output logic                 fault_o
);
  import fabric_pkg::*;

  region_e     region;
  logic        cpu_act;
  logic        local_start;
  logic [31:0] ctrl_rd;
  logic        ack_q;
  logic        err_q;
  logic [31:0] rdat_q;
  logic [31:0] base_q;
  logic [31:0] len_q;
  logic [1:0]  ctl_q;  // bit 1 int_en, bit 0 video enable
  logic        fault_q;

  always_comb begin
    case (cpu_req_i.adr[`FAB_REGION_MSB:`FAB_REGION_LSB])
      `FAB_REGION_MEM:  region = REG_MEM;
      `FAB_REGION_CTRL: region = REG_CTRL;
      default:          region = REG_NONE;
    endcase
  end

  assign cpu_act = cpu_req_i.cyc & cpu_req_i.stb;
  // ctrl and unmapped accesses complete here, no restart during the ack cycle
  assign local_start = cpu_act & (region != REG_MEM) & ~ack_q;

  always_comb begin
    mem_req_o = cpu_req_i;
    mem_req_o.stb = cpu_req_i.stb & (region == REG_MEM);
  end

  always_comb begin
    case (cpu_req_i.adr[3:2])
      2'd0:    ctrl_rd = base_q;
      2'd1:    ctrl_rd = len_q;
      2'd2:    ctrl_rd = {30'd0, ctl_q};
      default: ctrl_rd = 32'd0;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      base_q <= 32'd0;
      len_q <= 32'd0;
      ctl_q <= 2'b00;
      fault_q <= 1'b0;
    end else begin
      ack_q <= local_start;
      if (local_start) begin
        err_q <= (region == REG_NONE);
      end
      if (local_start && region == REG_NONE) begin
        fault_q <= 1'b1;  // sticky until a mapped access
      end else if (cpu_act && region != REG_NONE) begin
        fault_q <= 1'b0;
      end
      if (local_start && region == REG_CTRL && cpu_req_i.we) begin
        case (cpu_req_i.adr[3:2])
          2'd0: base_q <= merge_bytes(base_q, cpu_req_i.dat, cpu_req_i.sel);
          2'd1: len_q <= merge_bytes(len_q, cpu_req_i.dat, cpu_req_i.sel);
          2'd2: begin
            if (cpu_req_i.sel[0]) ctl_q <= cpu_req_i.dat[1:0];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (local_start) begin
      rdat_q <= (region == REG_CTRL) ? ctrl_rd : 32'd0;
    end
  end

  // local ack and memory ack never overlap, one transaction at a time
  always_comb begin
    cpu_rsp_o = mem_rsp_i;
    if (ack_q) begin
      cpu_rsp_o.ack = 1'b1;
      cpu_rsp_o.err = err_q;
      cpu_rsp_o.dat = rdat_q;
    end
  end

  assign vid_base_o = base_q;
  assign vid_len_o = len_q;
  assign vid_en_o = ctl_q[0];
  assign int_en_o = ctl_q[1];
  assign fault_o = fault_q;

endmodule

// ==== src/fabric_pkg.sv ====
`include "fabric_params.svh"

package fabric_pkg;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [3:0]             sel;
    logic [`FAB_ADDR_W-1:0] adr;
    logic [31:0]            dat;
  } bus_req_t;

  typedef struct packed {
    logic        ack;  // single cycle pulse
    logic        err;
    logic [31:0] dat;
  } bus_rsp_t;

  typedef struct packed {
    logic        last;  // final word of a frame
    logic [31:0] dat;
  } pix_t;

  typedef enum logic [1:0] {
    REG_MEM,
    REG_CTRL,
    REG_NONE
  } region_e;

  typedef logic [2:0] irq_lvl_t;

  // merge new bytes into a word under sel
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

endpackage

// ==== src/fabric_params.svh ====
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// byte address width of every bus port
`define FAB_ADDR_W 32

// shared memory depth in 32-bit words
`define FAB_MEM_WORDS 256

// region field of the byte address
`define FAB_REGION_MSB 31
`define FAB_REGION_LSB 28

// mapped regions, anything else faults
`define FAB_REGION_MEM 4'h0
`define FAB_REGION_CTRL 4'h1

`endif
